// ==== source/warp_sched_pkg.sv ====
// ----------------------------------------
// 4 warps x 4 threads, 2 local barriers
// ----------------------------------------
package warp_sched_pkg;

    localparam int NUM_WARPS     = 4;
    localparam int NW_WIDTH      = 2;
    localparam int NUM_THREADS   = 4;
    localparam int XLEN          = 32;
    localparam int NUM_BARRIERS  = 2;
    localparam int NB_WIDTH      = 1;

    // outstanding issues toward fetch
    localparam int FETCH_CREDITS = 4;
    localparam int CREDIT_WIDTH  = 3;
    localparam int PENDING_WIDTH = 4;

    typedef enum logic [2:0] {
        OP_SPAWN  = 3'd0,
        OP_TMC    = 3'd1,
        OP_BRANCH = 3'd2,
        OP_BAR    = 3'd3,
        OP_UNLOCK = 3'd4
    } warp_ctl_op_e;

    typedef logic [NW_WIDTH-1:0]    wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [XLEN-1:0]        pc_t;
    typedef logic [NB_WIDTH-1:0]    bar_id_t;

endpackage

// ==== source/warp_ctl_decode.sv ====
// ----------------------------------------
// one command per cycle, no back-pressure
// unknown op values are dropped
// ----------------------------------------
module warp_ctl_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ctl_valid,
    input  warp_sched_pkg::warp_ctl_op_e  ctl_op,
    input  warp_sched_pkg::wid_t          ctl_wid,
    input  warp_sched_pkg::wmask_t        ctl_wmask,
    input  warp_sched_pkg::tmask_t        ctl_tmask,
    input  warp_sched_pkg::pc_t           ctl_pc,
    input  logic                          ctl_taken,
    input  warp_sched_pkg::bar_id_t       ctl_bar_id,
    input  warp_sched_pkg::wid_t          ctl_bar_size_m1,
    output logic                          spawn_valid,
    output logic                          tmc_valid,
    output logic                          branch_valid,
    output logic                          bar_valid,
    output logic                          unlock_valid,
    output warp_sched_pkg::wid_t          cmd_wid,
    output warp_sched_pkg::wmask_t        cmd_wmask,
    output warp_sched_pkg::tmask_t        cmd_tmask,
    output warp_sched_pkg::pc_t           cmd_pc,
    output logic                          cmd_taken,
    output warp_sched_pkg::bar_id_t       cmd_bar_id,
    output warp_sched_pkg::wid_t          cmd_bar_size_m1
);
    import warp_sched_pkg::*;

    // op to one-hot pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            spawn_valid  <= 1'b0;
            tmc_valid    <= 1'b0;
            branch_valid <= 1'b0;
            bar_valid    <= 1'b0;
            unlock_valid <= 1'b0;
        end else begin
            spawn_valid  <= ctl_valid && (ctl_op == OP_SPAWN);
            tmc_valid    <= ctl_valid && (ctl_op == OP_TMC);
            branch_valid <= ctl_valid && (ctl_op == OP_BRANCH);
            bar_valid    <= ctl_valid && (ctl_op == OP_BAR);
            unlock_valid <= ctl_valid && (ctl_op == OP_UNLOCK);
        end
    end

    // command fields, only meaningful next to a pulse
    always_ff @(posedge clk) begin
        if (ctl_valid) begin
            cmd_wid         <= ctl_wid;
            cmd_wmask       <= ctl_wmask;
            cmd_tmask       <= ctl_tmask;
            cmd_pc          <= ctl_pc;
            cmd_taken       <= ctl_taken;
            cmd_bar_id      <= ctl_bar_id;
            cmd_bar_size_m1 <= ctl_bar_size_m1;
        end
    end

    a_pulse_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({spawn_valid, tmc_valid, branch_valid, bar_valid, unlock_valid}));

endmodule

// ==== source/barrier_unit.sv ====
// ----------------------------------------
// local barriers only, no global release
// ----------------------------------------
module barrier_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     bar_valid,
    input  warp_sched_pkg::wid_t     cmd_wid,
    input  warp_sched_pkg::bar_id_t  cmd_bar_id,
    input  warp_sched_pkg::wid_t     cmd_bar_size_m1,
    output warp_sched_pkg::wmask_t   barrier_stalls
);
    import warp_sched_pkg::*;

    wmask_t              barrier_masks [NUM_BARRIERS];
    wmask_t              curr_mask;
    logic [NW_WIDTH:0]   wait_count;

    assign curr_mask = barrier_masks[cmd_bar_id];

    // warps already waiting on the addressed barrier
    always_comb begin
        wait_count = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            wait_count = wait_count + (NW_WIDTH+1)'(curr_mask[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BARRIERS; b++) begin
                barrier_masks[b] <= '0;
            end
            barrier_stalls <= '0;
        end else if (bar_valid) begin
            if (wait_count == {1'b0, cmd_bar_size_m1}) begin
                // last arrival releases everyone
                barrier_masks[cmd_bar_id] <= '0;
                barrier_stalls            <= barrier_stalls & ~curr_mask;
            end else begin
                barrier_masks[cmd_bar_id][cmd_wid] <= 1'b1;
                barrier_stalls[cmd_wid]            <= 1'b1;
            end
        end
    end

    a_no_double_arrival: assert property (@(posedge clk) disable iff (reset)
        bar_valid |-> !curr_mask[cmd_wid]);

endmodule

// ==== source/warp_scheduler.sv ====
// ----------------------------------------
// lowest ready warp wins; a fired warp stays
// stalled until its next control command
// ----------------------------------------
module warp_scheduler (
    input  logic                     clk,
    input  logic                     reset,
    input  warp_sched_pkg::pc_t      startup_pc,
    input  logic                     spawn_valid,
    input  logic                     tmc_valid,
    input  logic                     branch_valid,
    input  logic                     bar_valid,
    input  logic                     unlock_valid,
    input  warp_sched_pkg::wid_t     cmd_wid,
    input  warp_sched_pkg::wmask_t   cmd_wmask,
    input  warp_sched_pkg::tmask_t   cmd_tmask,
    input  warp_sched_pkg::pc_t      cmd_pc,
    input  logic                     cmd_taken,
    input  warp_sched_pkg::bar_id_t  cmd_bar_id,
    input  warp_sched_pkg::wid_t     cmd_bar_size_m1,
    input  logic                     issue_ready,
    output logic                     sel_valid,
    output warp_sched_pkg::wid_t     sel_wid,
    output warp_sched_pkg::pc_t      sel_pc,
    output warp_sched_pkg::tmask_t   sel_tmask,
    output warp_sched_pkg::wmask_t   active_warps
);
    import warp_sched_pkg::*;

    wmask_t  stalled_warps;
    wmask_t  active_n;
    wmask_t  stalled_n;
    wmask_t  barrier_stalls;
    wmask_t  ready_warps;
    tmask_t  thread_masks   [NUM_WARPS];
    tmask_t  thread_masks_n [NUM_WARPS];
    pc_t     warp_pcs       [NUM_WARPS];
    pc_t     warp_pcs_n     [NUM_WARPS];
    logic    any_cmd;
    logic    sel_fire;

    assign any_cmd  = spawn_valid | tmc_valid | branch_valid | bar_valid | unlock_valid;
    assign sel_fire = sel_valid && issue_ready;

    always_comb begin
        active_n       = active_warps;
        stalled_n      = stalled_warps;
        thread_masks_n = thread_masks;
        warp_pcs_n     = warp_pcs;

        if (spawn_valid) begin
            active_n = active_n | cmd_wmask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (cmd_wmask[i]) begin
                    thread_masks_n[i] = tmask_t'(1);
                    warp_pcs_n[i]     = cmd_pc;
                end
            end
        end
        // zero mask retires the warp
        if (tmc_valid) begin
            active_n[cmd_wid]       = (cmd_tmask != '0);
            thread_masks_n[cmd_wid] = cmd_tmask;
        end
        if (branch_valid && cmd_taken) begin
            warp_pcs_n[cmd_wid] = cmd_pc;
        end
        if (any_cmd) begin
            stalled_n[cmd_wid] = 1'b0;
        end

        // hold the warp until its instruction is decoded
        if (sel_fire) begin
            stalled_n[sel_wid]  = 1'b1;
            warp_pcs_n[sel_wid] = sel_pc + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps  <= wmask_t'(1);
            stalled_warps <= '0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                thread_masks[i] <= (i == 0) ? tmask_t'(1) : '0;
                warp_pcs[i]     <= (i == 0) ? startup_pc : '0;
            end
        end else begin
            active_warps  <= active_n;
            stalled_warps <= stalled_n;
            thread_masks  <= thread_masks_n;
            warp_pcs      <= warp_pcs_n;
        end
    end

    barrier_unit u_barrier_unit (
        .clk             (clk),
        .reset           (reset),
        .bar_valid       (bar_valid),
        .cmd_wid         (cmd_wid),
        .cmd_bar_id      (cmd_bar_id),
        .cmd_bar_size_m1 (cmd_bar_size_m1),
        .barrier_stalls  (barrier_stalls)
    );

    assign ready_warps = active_warps & ~(stalled_warps | barrier_stalls);

    // descending scan, so the lowest index is written last
    always_comb begin
        sel_valid = 1'b0;
        sel_wid   = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_valid = 1'b1;
                sel_wid   = wid_t'(i);
            end
        end
    end

    assign sel_pc    = warp_pcs[sel_wid];
    assign sel_tmask = thread_masks[sel_wid];

endmodule

// ==== source/issue_credit_out.sv ====
// ----------------------------------------
// fetch returns at most one credit a cycle
// ----------------------------------------
module issue_credit_out (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sel_valid,
    input  warp_sched_pkg::wid_t    sel_wid,
    input  warp_sched_pkg::pc_t     sel_pc,
    input  warp_sched_pkg::tmask_t  sel_tmask,
    input  logic                    credit_return,
    output logic                    issue_ready,
    output logic                    issue_valid,
    output warp_sched_pkg::wid_t    issue_wid,
    output warp_sched_pkg::pc_t     issue_pc,
    output warp_sched_pkg::tmask_t  issue_tmask
);
    import warp_sched_pkg::*;

    localparam logic [CREDIT_WIDTH-1:0] CREDIT_MAX = CREDIT_WIDTH'(FETCH_CREDITS);

    logic [CREDIT_WIDTH-1:0] credits;
    logic                    fire;

    assign issue_ready = (credits != '0);
    assign fire        = sel_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_MAX;
        end else if (fire && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!fire && credit_return && credits != CREDIT_MAX) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fire;
        end
    end

    // payload follows the fire
    always_ff @(posedge clk) begin
        if (fire) begin
            issue_wid   <= sel_wid;
            issue_pc    <= sel_pc;
            issue_tmask <= sel_tmask;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_MAX);

    a_no_return_when_full: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> credits != CREDIT_MAX);

endmodule

// ==== source/pending_instr_ctr.sv ====
// ----------------------------------------
// busy lags its cause by one cycle
// ----------------------------------------
module pending_instr_ctr (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  warp_sched_pkg::wid_t    issue_wid,
    input  logic                    commit_valid,
    input  warp_sched_pkg::wid_t    commit_wid,
    input  warp_sched_pkg::wmask_t  active_warps,
    output logic                    busy
);
    import warp_sched_pkg::*;

    logic [PENDING_WIDTH-1:0] pending [NUM_WARPS];
    wmask_t                   incr;
    wmask_t                   decr;
    wmask_t                   nonzero;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            incr[i]    = issue_valid && (issue_wid == wid_t'(i));
            decr[i]    = commit_valid && (commit_wid == wid_t'(i));
            nonzero[i] = (pending[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                pending[i] <= '0;
            end
            busy <= 1'b1;
        end else begin
            // same-warp issue and commit cancel
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (incr[i] && !decr[i]) begin
                    pending[i] <= pending[i] + 1'b1;
                end else if (decr[i] && !incr[i]) begin
                    pending[i] <= pending[i] - 1'b1;
                end
            end
            busy <= (active_warps != '0) || (nonzero != '0);
        end
    end

    a_no_commit_underflow: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> pending[commit_wid] != '0);

endmodule

// ==== source/warp_sched_top.sv ====
// ----------------------------------------
// startup_pc is sampled while reset is high
// ----------------------------------------
module warp_sched_top (
    input  logic                          clk,
    input  logic                          reset,
    input  warp_sched_pkg::pc_t           startup_pc,
    input  logic                          ctl_valid,
    input  warp_sched_pkg::warp_ctl_op_e  ctl_op,
    input  warp_sched_pkg::wid_t          ctl_wid,
    input  warp_sched_pkg::wmask_t        ctl_wmask,
    input  warp_sched_pkg::tmask_t        ctl_tmask,
    input  warp_sched_pkg::pc_t           ctl_pc,
    input  logic                          ctl_taken,
    input  warp_sched_pkg::bar_id_t       ctl_bar_id,
    input  warp_sched_pkg::wid_t          ctl_bar_size_m1,
    input  logic                          credit_return,
    input  logic                          commit_valid,
    input  warp_sched_pkg::wid_t          commit_wid,
    output logic                          issue_valid,
    output warp_sched_pkg::wid_t          issue_wid,
    output warp_sched_pkg::pc_t           issue_pc,
    output warp_sched_pkg::tmask_t        issue_tmask,
    output logic                          busy
);
    import warp_sched_pkg::*;

    // decoded command
    logic    spawn_valid, tmc_valid, branch_valid, bar_valid, unlock_valid;
    wid_t    cmd_wid;
    wmask_t  cmd_wmask;
    tmask_t  cmd_tmask;
    pc_t     cmd_pc;
    logic    cmd_taken;
    bar_id_t cmd_bar_id;
    wid_t    cmd_bar_size_m1;

    // selection toward the issue stage
    logic    sel_valid;
    wid_t    sel_wid;
    pc_t     sel_pc;
    tmask_t  sel_tmask;
    logic    issue_ready;
    wmask_t  active_warps;

    warp_ctl_decode   u_warp_ctl_decode   (.*);
    warp_scheduler    u_warp_scheduler    (.*);
    issue_credit_out  u_issue_credit_out  (.*);
    pending_instr_ctr u_pending_instr_ctr (.*);

endmodule

// ==== tb/tb_clock.sv ====
// ----------------------------------------
// free-running clock, period 8
// ----------------------------------------
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

// ==== tb/warp_sched_tb.sv ====
// ----------------------------------------
// credits and commits are returned by a monitor
// one cycle after each observed issue
// ----------------------------------------
module warp_sched_tb;
    import warp_sched_pkg::*;

    localparam int  NUM_TESTS = 6;
    localparam int  TIMEOUT   = NUM_TESTS * 400 * 8;
    localparam pc_t START_PC  = 32'h0000_1000;

    logic         clk;
    logic         reset;
    pc_t          startup_pc;
    logic         ctl_valid;
    warp_ctl_op_e ctl_op;
    wid_t         ctl_wid;
    wmask_t       ctl_wmask;
    tmask_t       ctl_tmask;
    pc_t          ctl_pc;
    logic         ctl_taken;
    bar_id_t      ctl_bar_id;
    wid_t         ctl_bar_size_m1;
    logic         credit_return;
    logic         commit_valid;
    wid_t         commit_wid;
    logic         issue_valid;
    wid_t         issue_wid;
    pc_t          issue_pc;
    tmask_t       issue_tmask;
    logic         busy;

    // reference model of the warp state
    wmask_t       m_active;
    wmask_t       m_stall;
    wmask_t       m_bar_stall;
    wmask_t       m_bar [NUM_BARRIERS];
    tmask_t       m_mask [NUM_WARPS];
    pc_t          m_pc [NUM_WARPS];
    int           m_pending [NUM_WARPS];
    int           m_credits;

    wid_t         q_wid [$];
    pc_t          q_pc [$];
    tmask_t       q_tmask [$];
    wid_t         commit_q [$];
    logic         auto_credit;
    logic         commit_hold;
    int           credits_owed;
    int           value_errors;
    int           other_errors;
    int unsigned  seed_val;

    tb_clock u_tb_clock (.clk(clk));

    warp_sched_top u_warp_sched_top (.*);

    // capture issues, drive commits and credit returns
    always @(posedge clk) begin
        #1;
        if (commit_q.size() > 0 && !commit_hold) begin
            commit_valid = 1'b1;
            commit_wid   = commit_q.pop_front();
            m_pending[commit_wid]--;
        end else begin
            commit_valid = 1'b0;
        end
        if (issue_valid) begin
            q_wid.push_back(issue_wid);
            q_pc.push_back(issue_pc);
            q_tmask.push_back(issue_tmask);
            commit_q.push_back(issue_wid);
            m_pending[issue_wid]++;
        end
        if (auto_credit && issue_valid) begin
            credit_return = 1'b1;
            m_credits++;
        end else if (credits_owed > 0) begin
            credit_return = 1'b1;
            credits_owed--;
            m_credits++;
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic check_issue(input wid_t exp_wid, input pc_t exp_pc, input tmask_t exp_tmask);
        int     waited;
        wid_t   got_wid;
        pc_t    got_pc;
        tmask_t got_tmask;
        waited = 0;
        while (q_wid.size() == 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (q_wid.size() == 0) begin
            $display("no issue from warp %0d arrived within 50 cycles", exp_wid);
            other_errors++;
        end else begin
            got_wid   = q_wid.pop_front();
            got_pc    = q_pc.pop_front();
            got_tmask = q_tmask.pop_front();
            if (got_wid !== exp_wid) begin
                $display("FAILED issue_wid: expected %h, got %h", exp_wid, got_wid);
                value_errors++;
            end
            if (got_pc !== exp_pc) begin
                $display("FAILED issue_pc: expected %h, got %h", exp_pc, got_pc);
                value_errors++;
            end
            if (got_tmask !== exp_tmask) begin
                $display("FAILED issue_tmask: expected %h, got %h", exp_tmask, got_tmask);
                value_errors++;
            end
        end
    endtask

    task automatic check_busy(input logic exp_busy);
        if (busy !== exp_busy) begin
            $display("FAILED busy: expected %h, got %h", exp_busy, busy);
            value_errors++;
        end
    endtask

    function automatic logic model_busy();
        logic any_pending;
        any_pending = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            any_pending = any_pending || (m_pending[w] != 0);
        end
        return (m_active != '0) || any_pending;
    endfunction

    task automatic send_cmd(input warp_ctl_op_e op, input wid_t wid, input wmask_t wmask,
                            input tmask_t tmask, input pc_t pc, input logic taken,
                            input bar_id_t bar, input wid_t size_m1);
        @(posedge clk);
        #1;
        ctl_valid       = 1'b1;
        ctl_op          = op;
        ctl_wid         = wid;
        ctl_wmask       = wmask;
        ctl_tmask       = tmask;
        ctl_pc          = pc;
        ctl_taken       = taken;
        ctl_bar_id      = bar;
        ctl_bar_size_m1 = size_m1;
        @(posedge clk);
        #1;
        ctl_valid = 1'b0;
        case (op)
            OP_SPAWN: begin
                m_active = m_active | wmask;
                for (int w = 0; w < NUM_WARPS; w++) begin
                    if (wmask[w]) begin
                        m_mask[w] = tmask_t'(1);
                        m_pc[w]   = pc;
                    end
                end
            end
            OP_TMC: begin
                m_active[wid] = (tmask != '0);
                m_mask[wid]   = tmask;
            end
            OP_BRANCH: begin
                if (taken) begin
                    m_pc[wid] = pc;
                end
            end
            OP_BAR: begin
                if ($countones(m_bar[bar]) == int'(size_m1)) begin
                    m_bar_stall = m_bar_stall & ~m_bar[bar];
                    m_bar[bar]  = '0;
                end else begin
                    m_bar[bar][wid] = 1'b1;
                    m_bar_stall[wid] = 1'b1;
                end
            end
            default: begin
            end
        endcase
        m_stall[wid] = 1'b0;
    endtask

    task automatic unlock_warp(input wid_t wid);
        send_cmd(OP_UNLOCK, wid, '0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        #2;
        if (q_wid.size() != 0) begin
            $display("%0d unexpected issue(s), first one from warp %0d", q_wid.size(), q_wid[0]);
            other_errors++;
            q_wid.delete();
            q_pc.delete();
            q_tmask.delete();
        end
    endtask

    // ready warps issue lowest first, one per available credit
    task automatic drain_ready();
        wmask_t ready;
        int     avail;
        ready = m_active & ~m_stall & ~m_bar_stall;
        avail = m_credits;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (ready[w] && avail > 0) begin
                check_issue(wid_t'(w), m_pc[w], m_mask[w]);
                m_stall[w] = 1'b1;
                m_pc[w]    = m_pc[w] + 4;
                avail--;
                m_credits--;
            end
        end
        expect_quiet(12);
    endtask

    task automatic return_credits(input int n);
        credits_owed = n;
        wait (credits_owed == 0);
    endtask

    task automatic test_startup();
        check_busy(model_busy());
        drain_ready();
        expect_quiet(20);
        unlock_warp(0);
        drain_ready();
    endtask

    task automatic test_spawn_priority();
        pc_t spawn_pc;
        spawn_pc = $urandom & 32'hffff_fffc;
        send_cmd(OP_SPAWN, 0, 4'b1110, '0, spawn_pc, 1'b0, '0, '0);
        drain_ready();
        unlock_warp(2);
        drain_ready();
        unlock_warp(3);
        drain_ready();
        unlock_warp(1);
        drain_ready();
    endtask

    task automatic test_credit_backpressure();
        auto_credit = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            unlock_warp(wid_t'(w));
        end
        drain_ready();
        // no credits left, nothing may issue
        for (int w = 0; w < NUM_WARPS; w++) begin
            unlock_warp(wid_t'(w));
        end
        drain_ready();
        return_credits(1);
        drain_ready();
        return_credits(1);
        drain_ready();
        return_credits(2);
        drain_ready();
        auto_credit = 1'b1;
        return_credits(FETCH_CREDITS);
    endtask

    task automatic test_tmask_branch();
        pc_t target;
        send_cmd(OP_TMC, 1, '0, 4'b1011, '0, 1'b0, '0, '0);
        drain_ready();
        send_cmd(OP_TMC, 3, '0, 4'b0000, '0, 1'b0, '0, '0);
        drain_ready();
        unlock_warp(3);
        drain_ready();
        target = $urandom & 32'hffff_fffc;
        send_cmd(OP_BRANCH, 1, '0, '0, target, 1'b1, '0, '0);
        drain_ready();
        target = $urandom & 32'hffff_fffc;
        send_cmd(OP_BRANCH, 2, '0, '0, target, 1'b0, '0, '0);
        drain_ready();
    endtask

    task automatic test_barrier();
        send_cmd(OP_BAR, 1, '0, '0, '0, 1'b0, 1'b0, 1);
        drain_ready();
        expect_quiet(20);
        send_cmd(OP_BAR, 2, '0, '0, '0, 1'b0, 1'b0, 1);
        drain_ready();
    endtask

    task automatic test_busy();
        check_busy(model_busy());
        commit_hold = 1'b1;
        unlock_warp(0);
        drain_ready();
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_cmd(OP_TMC, wid_t'(w), '0, '0, '0, 1'b0, '0, '0);
        end
        expect_quiet(8);
        // no warp active, one instruction still uncommitted
        check_busy(model_busy());
        commit_hold = 1'b0;
        expect_quiet(8);
        check_busy(model_busy());
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        startup_pc      = START_PC;
        ctl_valid       = 1'b0;
        ctl_op          = OP_UNLOCK;
        ctl_wid         = '0;
        ctl_wmask       = '0;
        ctl_tmask       = '0;
        ctl_pc          = '0;
        ctl_taken       = 1'b0;
        ctl_bar_id      = '0;
        ctl_bar_size_m1 = '0;
        credit_return   = 1'b0;
        commit_valid    = 1'b0;
        commit_wid      = '0;
        auto_credit     = 1'b1;
        commit_hold     = 1'b0;
        credits_owed    = 0;
        value_errors    = 0;
        other_errors    = 0;
        m_active        = wmask_t'(1);
        m_stall         = '0;
        m_bar_stall     = '0;
        m_credits       = FETCH_CREDITS;
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            m_bar[b] = '0;
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            m_mask[w]    = (w == 0) ? tmask_t'(1) : '0;
            m_pc[w]      = (w == 0) ? START_PC : '0;
            m_pending[w] = 0;
        end
        seed_val = $urandom(80102);
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_startup();
        test_spawn_priority();
        test_credit_backpressure();
        test_tmask_branch();
        test_barrier();
        test_busy();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/warp_sched_pkg.sv
source/warp_ctl_decode.sv
source/barrier_unit.sv
source/warp_scheduler.sv
source/issue_credit_out.sv
source/pending_instr_ctr.sv
source/warp_sched_top.sv
tb/tb_clock.sv
tb/warp_sched_tb.sv

// ==== Bender.yml ====
package:
  name: warp_sched

sources:
  - source/warp_sched_pkg.sv
  - source/warp_ctl_decode.sv
  - source/barrier_unit.sv
  - source/warp_scheduler.sv
  - source/issue_credit_out.sv
  - source/pending_instr_ctr.sv
  - source/warp_sched_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/warp_sched_tb.sv
